// ==== compile.f ====
+incdir+design
design/rvPkg.sv
design/regFile.sv
design/alu.sv
design/fetchUnit.sv
design/decodeUnit.sv
design/executeUnit.sv
design/memWbUnit.sv
design/hazardUnit.sv
design/rvCore.sv
bench/clockGen.sv
bench/coreTb.sv

// ==== Makefile ====
# Verilator build and run of the core testbench
TOP := coreTb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): compile.f $(wildcard design/*.sv design/*.svh bench/*.sv)
	verilator --binary --timing -f compile.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f compile.f --top-module rvCore

clean:
	rm -rf obj_dir

// ==== bench/coreTb.sv ====
/* Testbench for rvCore. Runs a random program from seed 55 and compares every store
   with an in-order instruction-set model. Memories answer combinationally.
   Data region for lw/sw is 0x100 to 0x13F. The program ends in a jal to itself. */
`timescale 1ns/100ps
`include "core_defs.svh"

module coreTb;
  import rvPkg::*;

  localparam int BODY_LEN = 60;  // random instructions after the register setup

  logic   clk;
  logic   reset;
  word_t  pc;
  word_t  instr;
  logic   memWrite;
  word_t  memAddr;
  word_t  memWriteData;
  word_t  memReadData;

  word_t  imem [0:127];
  word_t  dmem [0:255];
  word_t  modelMem [0:255];
  word_t  expAddr [$];
  word_t  expData [$];
  integer seed;
  int     progLen;
  int     expCount;
  int     storeCount;
  word_t  haltAddr;
  logic   programReady = 1'b0;

  clockGen clocks (
    .clk   (clk),
    .reset (reset)
  );

  rvCore dut (
    .clk          (clk),
    .reset        (reset),
    .pc           (pc),
    .instr        (instr),
    .memWrite     (memWrite),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memReadData  (memReadData)
  );

  assign instr       = imem[pc[8:2]];
  assign memReadData = dmem[memAddr[9:2]];

  always @(posedge clk) begin
    if (memWrite) begin
      dmem[memAddr[9:2]] = memWriteData;
    end
  end

  //////////////////////////////////////////////////
  // checking

  task automatic stopOnError();
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkValue(string name, word_t got, word_t expected);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
      stopOnError();
    end
  endtask

  //////////////////////////////////////////////////
  // program generation

  function automatic int pick(int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic word_t fillWord(word_t addr);
    return {addr[15:0], ~addr[31:16]} ^ 32'h3C5A_96E1;
  endfunction

  // RV32I encodings
  function automatic word_t encR(word_t f7, word_t rs2, word_t rs1, word_t f3, word_t rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OP_RTYPE};
  endfunction

  function automatic word_t encI(word_t imm, word_t rs1, word_t f3, word_t rd, logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic word_t encS(word_t imm, word_t rs2, word_t rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OP_STORE};
  endfunction

  function automatic word_t encB(word_t imm, word_t rs2, word_t rs1, word_t f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], `OP_BRANCH};
  endfunction

  function automatic word_t encJ(word_t imm, word_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `OP_JAL};
  endfunction

  task automatic emit(word_t w);
    imem[progLen[6:0]] = w;
    progLen++;
  endtask

  // one of the ten register-register operations
  task automatic emitAluOp(word_t rd, word_t rs1, word_t rs2);
    int    kind;
    word_t f3;
    word_t f7;
    kind = pick(10);
    f7 = (kind == 1 || kind == 7) ? 32'h20 : 32'h0;  // sub and sra
    case (kind)
      0, 1:    f3 = 0;
      2:       f3 = 1;
      3:       f3 = 2;
      4:       f3 = 3;
      5:       f3 = 4;
      6, 7:    f3 = 5;
      8:       f3 = 6;
      default: f3 = 7;
    endcase
    emit(encR(f7, rs2, rs1, f3, rd));
  endtask

  task automatic buildProgram();
    int    i;
    word_t rd;
    for (i = 0; i < 128; i++) begin
      imem[i[6:0]] = '0;
    end
    for (i = 0; i < 256; i++) begin
      dmem[i[7:0]] = fillWord(i * 4);
    end
    progLen = 0;
    for (i = 1; i <= 7; i++) begin
      emit(encI(pick(4096) - 2048, 0, 0, i, `OP_ITYPE));  // defined start values
    end
    while (progLen < 7 + BODY_LEN) begin
      rd = 1 + pick(7);
      case (pick(10))
        0, 1: emit(encI(pick(4096) - 2048, pick(8), 0, rd, `OP_ITYPE));
        6: begin
          emit(encI(32'h100 + 4 * pick(16), 0, 2, rd, `OP_LOAD));
          if (pick(2) == 1) begin
            emitAluOp(1 + pick(7), rd, pick(8));  // load-use
          end
        end
        7:       emit(encS(32'h100 + 4 * pick(16), pick(8), 0));
        8:       emit(encB(8 + 4 * pick(3), pick(8), pick(8), pick(2)));
        9:       emit(encJ(8 + 4 * pick(3), rd));
        default: emitAluOp(rd, pick(8), pick(8));
      endcase
    end
    for (i = 1; i <= 7; i++) begin
      emit(encS(32'h100 + 4 * (i - 1), i, 0));  // dump x1 to x7
    end
    haltAddr = progLen * 4;
    emit(encJ(0, 0));
  endtask

  //////////////////////////////////////////////////
  // instruction-set model

  function automatic word_t aluRef(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic runModel();
    word_t x [0:31];
    word_t pcM;
    word_t ir;
    word_t a;
    word_t b;
    word_t addr;
    word_t nextPc;
    logic  taken;
    int    i;
    int    steps;
    for (i = 0; i < 32; i++) begin
      x[i[4:0]] = '0;
    end
    for (i = 0; i < 256; i++) begin
      modelMem[i[7:0]] = fillWord(i * 4);
    end
    pcM = `RESET_PC;
    steps = 0;
    while (pcM != haltAddr && steps < 1000) begin
      ir = imem[pcM[8:2]];
      a = x[ir[19:15]];
      b = x[ir[24:20]];
      nextPc = pcM + 4;
      case (ir[6:0])
        `OP_ITYPE: x[ir[11:7]] = a + {{20{ir[31]}}, ir[31:20]};  // addi only
        `OP_RTYPE: x[ir[11:7]] = aluRef(ir[14:12], ir[30], a, b);
        `OP_LOAD: begin
          addr = a + {{20{ir[31]}}, ir[31:20]};
          x[ir[11:7]] = modelMem[addr[9:2]];
        end
        `OP_STORE: begin
          addr = a + {{20{ir[31]}}, ir[31:25], ir[11:7]};
          modelMem[addr[9:2]] = b;
          expAddr.push_back(addr);
          expData.push_back(b);
        end
        `OP_BRANCH: begin
          taken = ir[12] ? (a != b) : (a == b);  // bne : beq
          if (taken) begin
            nextPc = pcM + {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
          end
        end
        `OP_JAL: begin
          x[ir[11:7]] = pcM + 4;
          nextPc = pcM + {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
        end
        default: ;
      endcase
      x[0] = '0;
      pcM = nextPc;
      steps++;
    end
    if (steps >= 1000) begin
      $display("ERROR: the model did not reach the halt instruction");
      stopOnError();
    end else begin
      expCount = expAddr.size();
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus and monitors

  // sampled on the falling edge, one cycle per store
  always @(negedge clk) begin
    if (!reset && memWrite) begin
      if (expAddr.size() == 0) begin
        $display("ERROR: the core stored more often than the model at %0t", $time);
        stopOnError();
      end else begin
        checkValue("memAddr", memAddr, expAddr.pop_front());
        checkValue("memWriteData", memWriteData, expData.pop_front());
        storeCount++;
      end
    end
  end

  initial begin
    int limit;
    wait (programReady);
    limit = progLen * 20 + 8;
    repeat (limit) @(posedge clk);
    $display("ERROR: the halt instruction was never reached within %0d cycles", limit);
    stopOnError();
  end

  initial begin
    seed = 55;
    storeCount = 0;
    buildProgram();
    runModel();
    programReady = 1'b1;
    @(negedge reset);
    checkValue("pc", pc, `RESET_PC);
    checkValue("memWrite", word_t'(memWrite), '0);
    repeat (3) begin
      @(negedge clk);
      checkValue("memWrite", word_t'(memWrite), '0);
    end
    while (pc !== haltAddr) begin
      @(negedge clk);
    end
    repeat (5) @(negedge clk);  // last stores still in flight
    checkValue("store count", word_t'(storeCount), word_t'(expCount));
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== bench/clockGen.sv ====
/* Testbench clock and reset. 10 ns period.
   Reset is held for 8 rising edges and released on a falling edge. */
`timescale 1ns/100ps

module clockGen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);  // release away from the rising edge
    reset = 1'b0;
  end

endmodule

// ==== design/rvCore.sv ====
/* Five-stage in-order RV32I subset core with no memories of its own.
   Instruction and data memory answer combinationally in the same cycle.
   A store is taken at the rising edge while memWrite is high. */
`timescale 1ns/100ps

module rvCore (
  input  logic         clk,
  input  logic         reset,
  output rvPkg::word_t pc,
  input  rvPkg::word_t instr,
  output logic         memWrite,
  output rvPkg::word_t memAddr,
  output rvPkg::word_t memWriteData,
  input  rvPkg::word_t memReadData
);
  import rvPkg::*;

  //////////////////////////////////////////////////
  // stage to stage wires

  word_t      instrD;
  word_t      pcD;
  word_t      pcPlus4D;
  regAddr_t   rs1D;
  regAddr_t   rs2D;
  word_t      rd1E;
  word_t      rd2E;
  word_t      immE;
  word_t      pcE;
  word_t      pcPlus4E;
  regAddr_t   rs1E;
  regAddr_t   rs2E;
  regAddr_t   rdE;
  aluCtrl_t   aluCtrlE;
  logic       aluSrcImmE;
  logic       regWriteE;
  logic       memWriteE;
  logic       branchE;
  logic       jumpE;
  logic       branchNeE;
  logic       isLoadE;
  resultSel_t resultSelE;
  logic       redirectE;
  word_t      targetE;
  word_t      pcPlus4M;
  regAddr_t   rdM;
  logic       regWriteM;
  resultSel_t resultSelM;
  word_t      resultW;
  regAddr_t   rdW;
  logic       regWriteW;

  // hazard control
  fwdSel_t    fwdA;
  fwdSel_t    fwdB;
  logic       stallF;
  logic       stallD;
  logic       flushD;
  logic       flushE;

  //////////////////////////////////////////////////
  // stages

  fetchUnit fetch (
    .pcF (pc),
    .*
  );

  decodeUnit decode (.*);

  executeUnit execute (
    .aluResultM (memAddr),
    .writeDataM (memWriteData),
    .memWriteM  (memWrite),
    .*
  );

  memWbUnit memWb (
    .aluResultM (memAddr),
    .*
  );

  hazardUnit hazard (.*);

endmodule

// ==== design/hazardUnit.sv ====
/* Forwarding, load-use stall and flush control. Purely combinational.
   The load-use check does not look at whether decode really reads rs2. */
`timescale 1ns/100ps
`include "core_defs.svh"

module hazardUnit (
  input  rvPkg::regAddr_t rs1D,
  input  rvPkg::regAddr_t rs2D,
  input  rvPkg::regAddr_t rs1E,
  input  rvPkg::regAddr_t rs2E,
  input  rvPkg::regAddr_t rdE,
  input  rvPkg::regAddr_t rdM,
  input  rvPkg::regAddr_t rdW,
  input  logic            isLoadE,
  input  logic            redirectE,
  input  logic            regWriteM,
  input  logic            regWriteW,
  output rvPkg::fwdSel_t  fwdA,
  output rvPkg::fwdSel_t  fwdB,
  output logic            stallF,
  output logic            stallD,
  output logic            flushD,
  output logic            flushE
);
  import rvPkg::*;

  logic loadUse;

  // the younger producer in memory wins over writeback
  function automatic fwdSel_t pickForward(regAddr_t rs, regAddr_t rdMem, regAddr_t rdWb,
                                          logic wrMem, logic wrWb);
    if (rs == '0) begin
      return `FWD_REG;
    end else if (wrMem && rs == rdMem) begin
      return `FWD_MEM;
    end else if (wrWb && rs == rdWb) begin
      return `FWD_WB;
    end
    return `FWD_REG;
  endfunction

  assign fwdA = pickForward(rs1E, rdM, rdW, regWriteM, regWriteW);
  assign fwdB = pickForward(rs2E, rdM, rdW, regWriteM, regWriteW);

  assign loadUse = isLoadE & ((rdE == rs1D) | (rdE == rs2D));

  assign stallF = loadUse;
  assign stallD = loadUse;
  assign flushD = redirectE;
  assign flushE = loadUse | redirectE;  // bubble into execute

endmodule

// ==== design/memWbUnit.sv ====
/* Memory/writeback register and result selection.
   Load data must be valid in the same cycle as the address. */
`timescale 1ns/100ps
`include "core_defs.svh"

module memWbUnit (
  input  logic              clk,
  input  logic              reset,
  input  rvPkg::word_t      aluResultM,
  input  rvPkg::word_t      memReadData,
  input  rvPkg::word_t      pcPlus4M,
  input  rvPkg::regAddr_t   rdM,
  input  logic              regWriteM,
  input  rvPkg::resultSel_t resultSelM,
  output rvPkg::word_t      resultW,
  output rvPkg::regAddr_t   rdW,
  output logic              regWriteW
);
  import rvPkg::*;

  word_t      aluResultW;
  word_t      readDataW;
  word_t      pcPlus4W;
  resultSel_t resultSelW;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      aluResultW <= '0;
      readDataW  <= '0;
      pcPlus4W   <= '0;
      rdW        <= '0;
      regWriteW  <= 1'b0;
      resultSelW <= `RES_ALU;
    end else begin
      aluResultW <= aluResultM;
      readDataW  <= memReadData;
      pcPlus4W   <= pcPlus4M;
      rdW        <= rdM;
      regWriteW  <= regWriteM;
      resultSelW <= resultSelM;
    end
  end

  always_comb begin
    case (resultSelW)
      `RES_MEM: resultW = readDataW;
      `RES_PC4: resultW = pcPlus4W;  // jal link
      default:  resultW = aluResultW;
    endcase
  end

endmodule

// ==== design/executeUnit.sv ====
/* Execute stage and the execute/memory register.
   Branches and jal resolve here. The target is always PC plus immediate.
   Forwarding from memory uses the ALU result, so a load there is never forwarded. */
`timescale 1ns/100ps
`include "core_defs.svh"

module executeUnit (
  input  logic              clk,
  input  logic              reset,
  input  rvPkg::word_t      rd1E,
  input  rvPkg::word_t      rd2E,
  input  rvPkg::word_t      immE,
  input  rvPkg::word_t      pcE,
  input  rvPkg::word_t      pcPlus4E,
  input  rvPkg::regAddr_t   rdE,
  input  rvPkg::aluCtrl_t   aluCtrlE,
  input  logic              aluSrcImmE,
  input  logic              regWriteE,
  input  logic              memWriteE,
  input  logic              branchE,
  input  logic              jumpE,
  input  logic              branchNeE,
  input  rvPkg::resultSel_t resultSelE,
  input  rvPkg::fwdSel_t    fwdA,
  input  rvPkg::fwdSel_t    fwdB,
  input  rvPkg::word_t      resultW,
  output logic              redirectE,
  output rvPkg::word_t      targetE,
  output rvPkg::word_t      aluResultM,
  output rvPkg::word_t      writeDataM,
  output rvPkg::word_t      pcPlus4M,
  output rvPkg::regAddr_t   rdM,
  output logic              regWriteM,
  output logic              memWriteM,
  output rvPkg::resultSel_t resultSelM
);
  import rvPkg::*;

  word_t srcA;
  word_t fwdDataB;  // forwarded rs2, also the store data
  word_t srcB;
  word_t aluResultE;
  logic  zeroE;

  function automatic word_t pickOperand(fwdSel_t sel, word_t regVal, word_t memVal,
                                        word_t wbVal);
    case (sel)
      `FWD_MEM: return memVal;
      `FWD_WB:  return wbVal;
      default:  return regVal;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // operands, alu and branch decision

  assign srcA     = pickOperand(fwdA, rd1E, aluResultM, resultW);
  assign fwdDataB = pickOperand(fwdB, rd2E, aluResultM, resultW);
  assign srcB     = aluSrcImmE ? immE : fwdDataB;

  alu alu0 (
    .a      (srcA),
    .b      (srcB),
    .ctrl   (aluCtrlE),
    .result (aluResultE),
    .zero   (zeroE)
  );

  assign targetE   = pcE + immE;
  assign redirectE = jumpE | (branchE & (zeroE ^ branchNeE));  // bne flips the test

  //////////////////////////////////////////////////
  // execute/memory register

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      aluResultM <= '0;
      writeDataM <= '0;
      pcPlus4M   <= '0;
      rdM        <= '0;
      regWriteM  <= 1'b0;
      memWriteM  <= 1'b0;
      resultSelM <= `RES_ALU;
    end else begin
      aluResultM <= aluResultE;  // also the data memory address
      writeDataM <= fwdDataB;
      pcPlus4M   <= pcPlus4E;
      rdM        <= rdE;
      regWriteM  <= regWriteE;
      memWriteM  <= memWriteE;
      resultSelM <= resultSelE;
    end
  end

endmodule

// ==== design/decodeUnit.sv ====
/* Decode stage with the register file and the decode/execute register.
   Unknown opcodes, and branches other than beq/bne, decode as no-ops.
   A value written back in this cycle is already visible to the reads. */
`timescale 1ns/100ps
`include "core_defs.svh"

module decodeUnit (
  input  logic              clk,
  input  logic              reset,
  input  logic              flushE,
  input  rvPkg::word_t      instrD,
  input  rvPkg::word_t      pcD,
  input  rvPkg::word_t      pcPlus4D,
  input  rvPkg::regAddr_t   rdW,
  input  logic              regWriteW,
  input  rvPkg::word_t      resultW,
  output rvPkg::regAddr_t   rs1D,
  output rvPkg::regAddr_t   rs2D,
  output rvPkg::word_t      rd1E,
  output rvPkg::word_t      rd2E,
  output rvPkg::word_t      immE,
  output rvPkg::word_t      pcE,
  output rvPkg::word_t      pcPlus4E,
  output rvPkg::regAddr_t   rs1E,
  output rvPkg::regAddr_t   rs2E,
  output rvPkg::regAddr_t   rdE,
  output rvPkg::aluCtrl_t   aluCtrlE,
  output logic              aluSrcImmE,
  output logic              regWriteE,
  output logic              memWriteE,
  output logic              branchE,
  output logic              jumpE,
  output logic              branchNeE,
  output logic              isLoadE,
  output rvPkg::resultSel_t resultSelE
);
  import rvPkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7b5;
  regAddr_t   rdD;
  word_t      rd1D;
  word_t      rd2D;
  word_t      immD;
  immSel_t    immSel;
  aluCtrl_t   functCtrl;
  aluCtrl_t   aluCtrlD;
  resultSel_t resultSelD;
  logic       aluSrcImmD;
  logic       regWriteD;
  logic       memWriteD;
  logic       branchD;
  logic       jumpD;
  logic       isLoadD;

  assign opcode   = instrD[6:0];
  assign funct3   = instrD[14:12];
  assign funct7b5 = instrD[30];
  assign rs1D     = instrD[19:15];
  assign rs2D     = instrD[24:20];
  assign rdD      = instrD[11:7];

  //////////////////////////////////////////////////
  // control decode

  // funct3 to alu code for register and immediate ops
  always_comb begin
    case (funct3)
      3'b000:  functCtrl = (opcode[5] && funct7b5) ? `ALU_SUB : `ALU_ADD;  // no subi
      3'b001:  functCtrl = `ALU_SLL;
      3'b010:  functCtrl = `ALU_SLT;
      3'b011:  functCtrl = `ALU_SLTU;
      3'b100:  functCtrl = `ALU_XOR;
      3'b101:  functCtrl = funct7b5 ? `ALU_SRA : `ALU_SRL;
      3'b110:  functCtrl = `ALU_OR;
      default: functCtrl = `ALU_AND;
    endcase
  end

  always_comb begin
    regWriteD  = 1'b0;
    memWriteD  = 1'b0;
    branchD    = 1'b0;
    jumpD      = 1'b0;
    aluSrcImmD = 1'b0;
    isLoadD    = 1'b0;
    resultSelD = `RES_ALU;
    immSel     = `IMM_I;
    aluCtrlD   = `ALU_ADD;  // address calc for lw/sw
    case (opcode)
      `OP_LOAD: begin
        regWriteD  = 1'b1;
        aluSrcImmD = 1'b1;
        isLoadD    = 1'b1;
        resultSelD = `RES_MEM;
      end
      `OP_STORE: begin
        memWriteD  = 1'b1;
        aluSrcImmD = 1'b1;
        immSel     = `IMM_S;
      end
      `OP_RTYPE: begin
        regWriteD = 1'b1;
        aluCtrlD  = functCtrl;
      end
      `OP_ITYPE: begin
        regWriteD  = 1'b1;
        aluSrcImmD = 1'b1;
        aluCtrlD   = functCtrl;
      end
      `OP_BRANCH: begin
        branchD  = (funct3[2:1] == 2'b00);  // beq and bne only
        immSel   = `IMM_B;
        aluCtrlD = `ALU_SUB;  // compare through the zero flag
      end
      `OP_JAL: begin
        regWriteD  = 1'b1;
        jumpD      = 1'b1;
        immSel     = `IMM_J;
        resultSelD = `RES_PC4;  // link value
      end
      default: ;
    endcase
  end

  always_comb begin
    case (immSel)
      `IMM_S:  immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
      `IMM_B:  immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
      `IMM_J:  immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
      default: immD = {{20{instrD[31]}}, instrD[31:20]};
    endcase
  end

  regFile regs (
    .clk       (clk),
    .rs1       (rs1D),
    .rs2       (rs2D),
    .rd        (rdW),
    .writeEn   (regWriteW),
    .writeData (resultW),
    .readData1 (rd1D),
    .readData2 (rd2D)
  );

  //////////////////////////////////////////////////
  // decode/execute register

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      {rd1E, rd2E, immE, pcE, pcPlus4E} <= '0;
      {rs1E, rs2E, rdE} <= '0;
      {aluCtrlE, aluSrcImmE, regWriteE, memWriteE} <= '0;
      {branchE, jumpE, branchNeE, isLoadE, resultSelE} <= '0;
    end else if (flushE) begin
      {rd1E, rd2E, immE, pcE, pcPlus4E} <= '0;  // bubble
      {rs1E, rs2E, rdE} <= '0;
      {aluCtrlE, aluSrcImmE, regWriteE, memWriteE} <= '0;
      {branchE, jumpE, branchNeE, isLoadE, resultSelE} <= '0;
    end else begin
      rd1E       <= rd1D;
      rd2E       <= rd2D;
      immE       <= immD;
      pcE        <= pcD;
      pcPlus4E   <= pcPlus4D;
      rs1E       <= rs1D;
      rs2E       <= rs2D;
      rdE        <= rdD;
      aluCtrlE   <= aluCtrlD;
      aluSrcImmE <= aluSrcImmD;
      regWriteE  <= regWriteD;
      memWriteE  <= memWriteD;
      branchE    <= branchD;
      jumpE      <= jumpD;
      branchNeE  <= branchD & funct3[0];
      isLoadE    <= isLoadD;
      resultSelE <= resultSelD;
    end
  end

endmodule

// ==== design/fetchUnit.sv ====
/* Program counter and fetch/decode register.
   Instruction memory must answer in the same cycle as pcF.
   A redirect and a load-use stall never occur together. */
`timescale 1ns/100ps
`include "core_defs.svh"

module fetchUnit (
  input  logic         clk,
  input  logic         reset,
  input  logic         stallF,
  input  logic         stallD,
  input  logic         flushD,
  input  logic         redirectE,
  input  rvPkg::word_t targetE,
  input  rvPkg::word_t instr,
  output rvPkg::word_t pcF,
  output rvPkg::word_t instrD,
  output rvPkg::word_t pcD,
  output rvPkg::word_t pcPlus4D
);
  import rvPkg::*;

  word_t pcPlus4F;
  word_t pcNext;

  assign pcPlus4F = pcF + word_t'(4);
  assign pcNext   = redirectE ? targetE : pcPlus4F;  // taken branch or jal

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pcF <= `RESET_PC;
    end else if (!stallF) begin
      pcF <= pcNext;
    end
  end

  // an all-zero instruction word decodes as a bubble
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      instrD   <= '0;
      pcD      <= '0;
      pcPlus4D <= '0;
    end else if (flushD) begin
      instrD   <= '0;  // wrong-path instruction
      pcD      <= '0;
      pcPlus4D <= '0;
    end else if (!stallD) begin
      instrD   <= instr;
      pcD      <= pcF;
      pcPlus4D <= pcPlus4F;
    end
  end

endmodule

// ==== design/alu.sv ====
/* Integer ALU for the ten RV32I register operations.
   Shift amounts use the low five bits of b. Unknown codes give zero. */
`timescale 1ns/100ps
`include "core_defs.svh"

module alu (
  input  rvPkg::word_t    a,
  input  rvPkg::word_t    b,
  input  rvPkg::aluCtrl_t ctrl,
  output rvPkg::word_t    result,
  output logic            zero
);
  import rvPkg::*;

  word_t bInv;
  word_t sum;
  logic  overflow;

  // one adder serves add, sub and slt
  assign bInv = ctrl[0] ? ~b : b;
  assign sum  = a + bInv + word_t'(ctrl[0]);
  assign overflow = ~(ctrl[0] ^ a[`XLEN-1] ^ b[`XLEN-1])
                  & (a[`XLEN-1] ^ sum[`XLEN-1]) & ~ctrl[1];

  always_comb begin
    case (ctrl)
      `ALU_ADD,
      `ALU_SUB:  result = sum;
      `ALU_AND:  result = a & b;
      `ALU_OR:   result = a | b;
      `ALU_XOR:  result = a ^ b;
      `ALU_SLL:  result = a << b[4:0];
      `ALU_SRL:  result = a >> b[4:0];
      `ALU_SRA:  result = $signed(a) >>> b[4:0];
      `ALU_SLT:  result = word_t'(overflow ^ sum[`XLEN-1]);  // sign corrected for overflow
      `ALU_SLTU: result = word_t'(a < b);
      default:   result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

// ==== design/regFile.sv ====
/* 31 general registers plus x0, which always reads as zero.
   Reads are combinational. The write lands on the falling clock edge. */
`timescale 1ns/100ps

module regFile (
  input  logic            clk,
  input  rvPkg::regAddr_t rs1,
  input  rvPkg::regAddr_t rs2,
  input  rvPkg::regAddr_t rd,
  input  logic            writeEn,
  input  rvPkg::word_t    writeData,
  output rvPkg::word_t    readData1,
  output rvPkg::word_t    readData2
);
  import rvPkg::*;

  word_t regs [1:31];  // no storage for x0

  // half-cycle write lets decode see the value in the same cycle
  always_ff @(negedge clk) begin
    if (writeEn && rd != '0) begin
      regs[rd] <= writeData;
    end
  end

  assign readData1 = (rs1 == '0) ? '0 : regs[rs1];
  assign readData2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== design/rvPkg.sv ====
/* Vector types shared by all core RTL. Widths follow core_defs.svh. */
`include "core_defs.svh"

package rvPkg;

  typedef logic [`XLEN-1:0]       word_t;       // data word or byte address
  typedef logic [`REG_ADDR_W-1:0] regAddr_t;
  typedef logic [3:0]             aluCtrl_t;    // one of the ALU_* codes
  typedef logic [1:0]             immSel_t;
  typedef logic [1:0]             resultSel_t;  // writeback source
  typedef logic [1:0]             fwdSel_t;

endpackage

// ==== design/core_defs.svh ====
/* Widths, reset address and encodings of the RV32I subset core.
   Only the opcodes the core executes are listed. Any other opcode runs as a no-op. */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define RESET_PC    32'h0000_0000

// major opcodes
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_RTYPE    7'b0110011
`define OP_ITYPE    7'b0010011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111

// alu codes (bit 0 set inverts operand b)
`define ALU_ADD     4'b0000
`define ALU_SUB     4'b0001
`define ALU_AND     4'b0010
`define ALU_OR      4'b0011
`define ALU_SLL     4'b0100
`define ALU_SLT     4'b0101
`define ALU_XOR     4'b0110
`define ALU_SRL     4'b0111
`define ALU_SLTU    4'b1000
`define ALU_SRA     4'b1111

`define IMM_I       2'd0
`define IMM_S       2'd1
`define IMM_B       2'd2
`define IMM_J       2'd3

`define RES_ALU     2'd0
`define RES_MEM     2'd1
`define RES_PC4     2'd2

`define FWD_REG     2'd0
`define FWD_WB      2'd1
`define FWD_MEM     2'd2

`endif
